// ==== Bender.yml ====
package:
  name: bp_checkpoint

sources:
  - rtl/corep_pkg.sv
  - rtl/distram_1rport_1wport.sv
  - rtl/bcb.sv
  - rtl/gbl_hist.sv
  - rtl/ras.sv
  - rtl/bp_checkpoint_top.sv
  - target: test
    files:
      - tb/tb_bp_checkpoint.sv

// ==== flist.f ====
rtl/corep_pkg.sv
rtl/distram_1rport_1wport.sv
rtl/bcb.sv
rtl/gbl_hist.sv
rtl/ras.sv
rtl/bp_checkpoint_top.sv
tb/tb_bp_checkpoint.sv

// ==== rtl/bcb.sv ====
// branch checkpoint buffer, wrapping save pointer over a distributed RAM
`timescale 1ns/1ns
`default_nettype none

module bcb import corep_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // save side
    input  logic        save_valid,
    input  bcb_info_t   save_bcb_info,
    output bcb_idx_t    save_bcb_idx,

    // restore side
    input  bcb_idx_t    restore_bcb_idx,
    output bcb_info_t   restore_bcb_info
);

    // the snapshot only changes when a branch goes by
    // so non-branch cycles can share one entry
    // write every cycle, step to the next entry on a branch

    // ----------------------------------------------------------
    // next pointer

    bcb_idx_t save_bcb_idx_plus_1;

    generate
        if ((BCB_ENTRIES & (BCB_ENTRIES - 1)) == 0) begin : gen_pow2_wrap
            // index width matches entry count, natural rollover
            assign save_bcb_idx_plus_1 = save_bcb_idx + 1'b1;
        end
        else begin : gen_manual_wrap
            // last entry goes back to entry 0
            always_comb begin
                if (save_bcb_idx == bcb_idx_t'(BCB_ENTRIES - 1)) begin
                    save_bcb_idx_plus_1 = '0;
                end
                else begin
                    save_bcb_idx_plus_1 = save_bcb_idx + 1'b1;
                end
            end
        end
    endgenerate

    // save pointer
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            save_bcb_idx <= '0;
        end
        else if (save_valid) begin
            save_bcb_idx <= save_bcb_idx_plus_1;
        end
    end

    // ----------------------------------------------------------
    // checkpoint storage

    distram_1rport_1wport #(
        .INNER_WIDTH ($bits(bcb_info_t)),
        .OUTER_WIDTH (BCB_ENTRIES)
    ) u_distram (
        .CLK    (CLK),
        .rindex (restore_bcb_idx),
        .rdata  (restore_bcb_info),
        .wen    (1'b1),
        .windex (save_bcb_idx),
        .wdata  (save_bcb_info)
    );

endmodule

`default_nettype wire

// ==== rtl/bp_checkpoint_top.sv ====
// predictor checkpoint top joining global history, RAS and checkpoint buffer
`timescale 1ns/1ns
`default_nettype none

module bp_checkpoint_top import corep_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // predicted branch in fetch
    input  logic        branch_valid,
    input  logic        branch_taken,
    input  logic        branch_is_call,
    input  logic        branch_is_ret,
    input  ras_addr_t   call_addr,
    input  btb_way_t    btb_hit_way,

    // mispredict restore from backend
    input  logic        restore_valid,
    input  bcb_idx_t    restore_bcb_idx,
    input  logic        restore_taken,
    input  logic        restore_is_call,
    input  logic        restore_is_ret,
    input  ras_addr_t   restore_call_addr,

    output bcb_idx_t    save_bcb_idx,
    output gh_t         gh,
    output ras_addr_t   ras_top,
    output btb_way_t    restore_btb_hit_way
);

    // ----------------------------------------------------------
    // strobes and snapshot

    logic       spec_valid;
    ras_idx_t   ras_idx;
    ras_cnt_t   ras_cnt;
    bcb_info_t  save_info;
    bcb_info_t  restore_info;

    // restore wins over a branch in the same cycle
    assign spec_valid = branch_valid & ~restore_valid;

    // current speculative state, written into the buffer every cycle
    assign save_info.gh          = gh;
    assign save_info.ras_idx     = ras_idx;
    assign save_info.ras_cnt     = ras_cnt;
    assign save_info.btb_hit_way = btb_hit_way;

    // saved way goes straight back out
    assign restore_btb_hit_way = restore_info.btb_hit_way;

    // ----------------------------------------------------------
    // state blocks

    bcb u_bcb (
        .CLK              (CLK),
        .nRST             (nRST),
        .save_valid       (spec_valid),
        .save_bcb_info    (save_info),
        .save_bcb_idx     (save_bcb_idx),
        .restore_bcb_idx  (restore_bcb_idx),
        .restore_bcb_info (restore_info)
    );

    gbl_hist u_gbl_hist (
        .CLK           (CLK),
        .nRST          (nRST),
        .update_valid  (spec_valid),
        .update_taken  (branch_taken),
        .restore_valid (restore_valid),
        .restore_gh    (restore_info.gh),
        .restore_taken (restore_taken),
        .gh            (gh)
    );

    ras u_ras (
        .CLK           (CLK),
        .nRST          (nRST),
        .push          (spec_valid & branch_is_call),
        .pop           (spec_valid & branch_is_ret),
        .push_addr     (call_addr),
        .restore_valid (restore_valid),
        .restore_idx   (restore_info.ras_idx),
        .restore_cnt   (restore_info.ras_cnt),
        .restore_push  (restore_is_call),
        .restore_pop   (restore_is_ret),
        .restore_addr  (restore_call_addr),
        .ras_top       (ras_top),
        .ras_idx       (ras_idx),
        .ras_cnt       (ras_cnt)
    );

endmodule

`default_nettype wire

// ==== rtl/corep_pkg.sv ====
// predictor sizes, index types and the branch checkpoint record
`default_nettype none

package corep_pkg;

    // ----------------------------------------------------------
    // predictor sizes

    // global history length in bits
    localparam int GH_WIDTH       = 8;
    // return address stack depth
    localparam int RAS_ENTRIES    = 8;
    localparam int RAS_ADDR_WIDTH = 32;
    localparam int BTB_WAYS       = 4;
    // not a power of two, pointer needs an explicit wrap
    localparam int BCB_ENTRIES    = 6;

    // ----------------------------------------------------------
    // index and payload types

    typedef logic [GH_WIDTH-1:0]                    gh_t;
    typedef logic [$clog2(RAS_ENTRIES)-1:0]         ras_idx_t;
    // count runs 0 to RAS_ENTRIES inclusive, so one extra bit
    typedef logic [$clog2(RAS_ENTRIES+1)-1:0]       ras_cnt_t;
    typedef logic [RAS_ADDR_WIDTH-1:0]              ras_addr_t;
    typedef logic [$clog2(BTB_WAYS)-1:0]            btb_way_t;
    typedef logic [$clog2(BCB_ENTRIES)-1:0]         bcb_idx_t;

    // ----------------------------------------------------------
    // checkpoint record

    // snapshot of speculative state taken before each branch
    typedef struct packed {
        gh_t        gh;
        ras_idx_t   ras_idx;
        ras_cnt_t   ras_cnt;
        btb_way_t   btb_hit_way;
    } bcb_info_t;

endpackage

`default_nettype wire

// ==== rtl/distram_1rport_1wport.sv ====
// distributed RAM with one synchronous write port and one combinational read port
`timescale 1ns/1ns
`default_nettype none

module distram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 8,
    // a single word still needs a one bit index
    localparam int INDEX_WIDTH = (OUTER_WIDTH > 1) ? $clog2(OUTER_WIDTH) : 1
) (
    input  logic                   CLK,

    // read port
    input  logic [INDEX_WIDTH-1:0] rindex,
    output logic [INNER_WIDTH-1:0] rdata,

    // write port
    input  logic                   wen,
    input  logic [INDEX_WIDTH-1:0] windex,
    input  logic [INNER_WIDTH-1:0] wdata
);

    // word array, contents undefined until first write
    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // write lands on the rising edge
    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

    // asynchronous read
    assign rdata = mem[rindex];

endmodule

`default_nettype wire

// ==== rtl/gbl_hist.sv ====
// global history shift register with speculative update and restore
`timescale 1ns/1ns
`default_nettype none

module gbl_hist import corep_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,

    // speculative update from predicted branches
    input  logic    update_valid,
    input  logic    update_taken,

    // restore from a mispredicted branch
    input  logic    restore_valid,
    input  gh_t     restore_gh,
    input  logic    restore_taken,

    output gh_t     gh
);

    // ----------------------------------------------------------
    // next history

    gh_t gh_next;

    always_comb begin
        gh_next = gh;
        if (restore_valid) begin
            // saved history plus the resolved direction
            gh_next = {restore_gh[GH_WIDTH-2:0], restore_taken};
        end
        else if (update_valid) begin
            // newest prediction enters at bit 0
            gh_next = {gh[GH_WIDTH-2:0], update_taken};
        end
    end

    // ----------------------------------------------------------
    // history register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            gh <= '0;
        end
        else begin
            gh <= gh_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ras.sv ====
// return address stack with push, pop, saturating count and pointer restore
`timescale 1ns/1ns
`default_nettype none

module ras import corep_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // speculative push and pop
    input  logic        push,
    input  logic        pop,
    input  ras_addr_t   push_addr,

    // restore from checkpoint, then apply resolved branch
    input  logic        restore_valid,
    input  ras_idx_t    restore_idx,
    input  ras_cnt_t    restore_cnt,
    input  logic        restore_push,
    input  logic        restore_pop,
    input  ras_addr_t   restore_addr,

    output ras_addr_t   ras_top,
    output ras_idx_t    ras_idx,
    output ras_cnt_t    ras_cnt
);

    // ----------------------------------------------------------
    // operation select

    ras_addr_t entries [RAS_ENTRIES];

    ras_idx_t  base_idx;
    ras_cnt_t  base_cnt;
    logic      do_push;
    logic      do_pop;
    ras_addr_t op_addr;
    ras_idx_t  idx_next;
    ras_cnt_t  cnt_next;

    // restore starts from the saved pointer and count
    assign base_idx = restore_valid ? restore_idx  : ras_idx;
    assign base_cnt = restore_valid ? restore_cnt  : ras_cnt;
    assign do_push  = restore_valid ? restore_push : push;
    assign do_pop   = restore_valid ? restore_pop  : pop;
    assign op_addr  = restore_valid ? restore_addr : push_addr;

    always_comb begin
        idx_next = base_idx;
        cnt_next = base_cnt;
        if (do_push) begin
            // pointer wraps, oldest entry overwritten when full
            idx_next = base_idx + 1'b1;
            if (base_cnt != ras_cnt_t'(RAS_ENTRIES)) begin
                cnt_next = base_cnt + 1'b1;
            end
        end
        else if (do_pop) begin
            idx_next = base_idx - 1'b1;
            // count floors at zero
            if (base_cnt != '0) begin
                cnt_next = base_cnt - 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ras_idx <= '0;
            ras_cnt <= '0;
            for (int i = 0; i < RAS_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end
        else begin
            ras_idx <= idx_next;
            ras_cnt <= cnt_next;
            // push writes the slot the pointer moves to
            if (do_push) begin
                entries[idx_next] <= op_addr;
            end
        end
    end

    // top of stack, zero when empty
    assign ras_top = (ras_cnt == '0) ? '0 : entries[ras_idx];

endmodule

`default_nettype wire

// ==== tb/tb_bp_checkpoint.sv ====
// testbench for the predictor checkpoint top with reference model, directed and random tests
`timescale 1ns/1ns
`default_nettype none

module tb_bp_checkpoint import corep_pkg::*; ();

    // tests run about 700 cycles so the limit leaves a wide margin
    localparam int MAX_CYCLES = 2000;
    localparam int RAND_ITERS = 600;
    // way driven during reset lands in entry 0
    localparam btb_way_t RESET_WAY = 2'd2;

    logic      CLK = 1'b0;
    logic      nRST;
    logic      branch_valid, branch_taken, branch_is_call, branch_is_ret;
    ras_addr_t call_addr;
    btb_way_t  btb_hit_way;
    logic      restore_valid;
    bcb_idx_t  restore_bcb_idx;
    logic      restore_taken, restore_is_call, restore_is_ret;
    ras_addr_t restore_call_addr;
    bcb_idx_t  save_bcb_idx;
    gh_t       gh;
    ras_addr_t ras_top;
    btb_way_t  restore_btb_hit_way;

    int        cycle_cnt = 0;
    int        err_cnt = 0;

    // ----------------------------------------------------------
    // reference model state
    gh_t       gh_m = '0;
    ras_addr_t ras_m [RAS_ENTRIES];
    ras_idx_t  idx_m = '0;
    ras_cnt_t  cnt_m = '0;
    bcb_idx_t  ptr_m = '0;
    gh_t       snap_gh [BCB_ENTRIES];
    ras_idx_t  snap_idx [BCB_ENTRIES];
    ras_cnt_t  snap_cnt [BCB_ENTRIES];
    btb_way_t  snap_way [BCB_ENTRIES];
    logic      snap_ok [BCB_ENTRIES];

    // inputs driven in the current cycle are consumed at the next edge
    logic      p_bv = 1'b0, p_taken = 1'b0, p_call = 1'b0, p_ret = 1'b0;
    ras_addr_t p_addr = '0;
    btb_way_t  p_way = RESET_WAY;
    logic      p_rv = 1'b0, p_rtaken = 1'b0, p_rcall = 1'b0, p_rret = 1'b0;
    bcb_idx_t  p_ridx = '0;
    ras_addr_t p_raddr = '0;

    bp_checkpoint_top DUT (
        .CLK (CLK), .nRST (nRST),
        .branch_valid (branch_valid), .branch_taken (branch_taken),
        .branch_is_call (branch_is_call), .branch_is_ret (branch_is_ret),
        .call_addr (call_addr), .btb_hit_way (btb_hit_way),
        .restore_valid (restore_valid), .restore_bcb_idx (restore_bcb_idx),
        .restore_taken (restore_taken), .restore_is_call (restore_is_call),
        .restore_is_ret (restore_is_ret), .restore_call_addr (restore_call_addr),
        .save_bcb_idx (save_bcb_idx), .gh (gh), .ras_top (ras_top),
        .restore_btb_hit_way (restore_btb_hit_way)
    );

    // 100 ns clock
    always #50 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // ----------------------------------------------------------
    // model of one clock edge
    task automatic model_edge();
        gh_t       r_gh;
        ras_idx_t  r_idx;
        ras_cnt_t  r_cnt;
        ras_idx_t  b_idx;
        ras_cnt_t  b_cnt;
        logic      push;
        logic      pop;
        ras_addr_t addr;
        // restore read sees the entry before this edge's write
        r_gh  = snap_gh[p_ridx];
        r_idx = snap_idx[p_ridx];
        r_cnt = snap_cnt[p_ridx];
        // snapshot of the state before the edge is taken every cycle
        snap_gh[ptr_m]  = gh_m;
        snap_idx[ptr_m] = idx_m;
        snap_cnt[ptr_m] = cnt_m;
        snap_way[ptr_m] = p_way;
        snap_ok[ptr_m]  = 1'b1;
        if (p_rv) begin
            gh_m  = {r_gh[GH_WIDTH-2:0], p_rtaken};
            b_idx = r_idx;
            b_cnt = r_cnt;
            push  = p_rcall;
            pop   = p_rret;
            addr  = p_raddr;
        end
        else begin
            b_idx = idx_m;
            b_cnt = cnt_m;
            push  = p_bv & p_call;
            pop   = p_bv & p_ret;
            addr  = p_addr;
            if (p_bv) begin
                gh_m  = {gh_m[GH_WIDTH-2:0], p_taken};
                ptr_m = (ptr_m == bcb_idx_t'(BCB_ENTRIES - 1)) ? '0 : ptr_m + 1'b1;
            end
        end
        if (push) begin
            // pointer wraps modulo 8 and count saturates at 8
            b_idx = b_idx + 1'b1;
            if (b_cnt < ras_cnt_t'(RAS_ENTRIES))
                b_cnt = b_cnt + 1'b1;
            ras_m[b_idx] = addr;
        end
        else if (pop) begin
            b_idx = b_idx - 1'b1;
            if (b_cnt != '0)
                b_cnt = b_cnt - 1'b1;
        end
        idx_m = b_idx;
        cnt_m = b_cnt;
    endtask

    task automatic check_outputs();
        ras_addr_t exp_top;
        exp_top = (cnt_m == '0) ? '0 : ras_m[idx_m];
        compare(save_bcb_idx, ptr_m, "save_bcb_idx");
        compare(gh, gh_m, "gh");
        compare(ras_top, exp_top, "ras_top");
        if (restore_bcb_idx < BCB_ENTRIES && snap_ok[restore_bcb_idx])
            compare(restore_btb_hit_way, snap_way[restore_bcb_idx], "restore_btb_hit_way");
    endtask

    // drive one cycle on the rising edge and check at the falling edge
    task automatic step(input logic bv, taken, call, ret, input ras_addr_t addr,
                        input btb_way_t way, input logic rv, input bcb_idx_t ridx,
                        input logic rtaken, rcall, rret, input ras_addr_t raddr);
        @(posedge CLK);
        model_edge();
        branch_valid <= bv;
        branch_taken <= taken;
        branch_is_call <= call;
        branch_is_ret <= ret;
        call_addr <= addr;
        btb_hit_way <= way;
        restore_valid <= rv;
        restore_bcb_idx <= ridx;
        restore_taken <= rtaken;
        restore_is_call <= rcall;
        restore_is_ret <= rret;
        restore_call_addr <= raddr;
        p_bv = bv;
        p_taken = taken;
        p_call = call;
        p_ret = ret;
        p_addr = addr;
        p_way = way;
        p_rv = rv;
        p_ridx = ridx;
        p_rtaken = rtaken;
        p_rcall = rcall;
        p_rret = rret;
        p_raddr = raddr;
        @(negedge CLK);
        check_outputs();
    endtask

    task automatic idle();
        step(0, 0, 0, 0, '0, '0, 0, '0, 0, 0, 0, '0);
    endtask

    task automatic branch(input logic taken, call, ret, input ras_addr_t addr,
                          input btb_way_t way);
        step(1, taken, call, ret, addr, way, 0, '0, 0, 0, 0, '0);
    endtask

    task automatic restore(input bcb_idx_t ridx, input logic rtaken, rcall, rret,
                           input ras_addr_t raddr);
        step(0, 0, 0, 0, '0, '0, 1, ridx, rtaken, rcall, rret, raddr);
    endtask

    // ----------------------------------------------------------
    // directed tests
    task automatic reset_values();
        @(negedge CLK);
        compare(save_bcb_idx, 0, "save_bcb_idx after reset");
        compare(gh, 0, "gh after reset");
        compare(ras_top, 0, "ras_top after reset");
        compare(restore_btb_hit_way, RESET_WAY, "entry 0 way after reset");
    endtask

    task automatic index_and_history();
        gh_t pattern;
        pattern = 8'b1011_0010;
        // msb first so gh ends equal to the pattern
        for (int i = 0; i < 8; i++) begin
            branch(pattern[7-i], 0, 0, '0, btb_way_t'(i));
            idle();
            compare(save_bcb_idx, (i + 1) % BCB_ENTRIES, "checkpoint index");
        end
        compare(gh, pattern, "gh after taken bits");
    endtask

    task automatic calls_and_returns();
        for (int i = 0; i < 9; i++)
            branch(1, 1, 0, 32'h1000 + 4 * i, btb_way_t'(i));
        idle();
        // ninth push replaced the oldest one
        compare(ras_top, 32'h1020, "ras_top after nine calls");
        for (int i = 0; i < 10; i++)
            branch(0, 0, 1, '0, '0);
        idle();
        compare(ras_top, 0, "ras_top after pops past empty");
    endtask

    task automatic history_restore();
        bcb_idx_t cp_idx [4];
        gh_t      cp_gh [4];
        btb_way_t cp_way [4];
        for (int i = 0; i < 4; i++) begin
            cp_idx[i] = ptr_m;
            cp_gh[i]  = gh_m;
            cp_way[i] = btb_way_t'(3 - i);
            branch(i[0], 0, 0, '0, cp_way[i]);
            idle();
        end
        restore(cp_idx[1], 1, 0, 0, '0);
        compare(restore_btb_hit_way, cp_way[1], "way of checkpoint 1");
        idle();
        compare(gh, {cp_gh[1][GH_WIDTH-2:0], 1'b1}, "gh restored to checkpoint 1");
        restore(cp_idx[3], 0, 0, 0, '0);
        compare(restore_btb_hit_way, cp_way[3], "way of checkpoint 3");
        idle();
        compare(gh, {cp_gh[3][GH_WIDTH-2:0], 1'b0}, "gh restored to checkpoint 3");
    endtask

    task automatic ras_restore();
        bcb_idx_t  cp;
        cp = ptr_m;
        branch(0, 0, 0, '0, 2'd1);
        branch(1, 1, 0, 32'hA000_0004, '0);
        branch(1, 1, 0, 32'hA000_0008, '0);
        branch(1, 1, 0, 32'hA000_000C, '0);
        idle();
        // resolved branch was really a call
        restore(cp, 1, 1, 0, 32'hC0DE_0000);
        idle();
        compare(ras_top, 32'hC0DE_0000, "ras_top after restore with call");
        branch(1, 1, 0, 32'hB000_0001, '0);
        idle();
        cp = ptr_m;
        branch(0, 0, 0, '0, '0);
        branch(1, 1, 0, 32'hB000_0002, '0);
        idle();
        // resolved branch was really a return
        restore(cp, 0, 0, 1, '0);
        idle();
        compare(ras_top, 32'hC0DE_0000, "ras_top after restore with return");
        // branch in the restore cycle is dropped
        cp = ptr_m;
        step(1, 1, 1, 0, 32'hDEAD_0000, 2'd3, 1, cp, 0, 0, 0, '0);
        idle();
        compare(save_bcb_idx, cp, "index after branch with restore");
        compare(ras_top, 32'hC0DE_0000, "ras_top after branch with restore");
    endtask

    task automatic random_mix();
        int unsigned rnd;
        int unsigned sel;
        int unsigned age;
        ras_addr_t   addr;
        bcb_idx_t    ridx;
        for (int n = 0; n < RAND_ITERS; n++) begin
            rnd  = $urandom;
            addr = $urandom;
            sel  = rnd % 10;
            if (sel == 0) begin
                // checkpoint one to five branches back
                age  = 1 + (rnd[15:8] % 5);
                ridx = bcb_idx_t'((ptr_m + BCB_ENTRIES - age) % BCB_ENTRIES);
                restore(ridx, rnd[16], rnd[17] & ~rnd[18], rnd[18], addr);
            end
            else if (sel < 6) begin
                branch(rnd[16], rnd[17] & ~rnd[18], rnd[18], addr, rnd[21:20]);
            end
            else begin
                idle();
            end
        end
        idle();
    endtask

    // ----------------------------------------------------------
    initial begin
        void'($urandom(2));
        nRST = 1'b0;
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        branch_is_call = 1'b0;
        branch_is_ret = 1'b0;
        call_addr = '0;
        btb_hit_way = RESET_WAY;
        restore_valid = 1'b0;
        restore_bcb_idx = '0;
        restore_taken = 1'b0;
        restore_is_call = 1'b0;
        restore_is_ret = 1'b0;
        restore_call_addr = '0;
        for (int i = 0; i < RAS_ENTRIES; i++)
            ras_m[i] = '0;
        for (int i = 0; i < BCB_ENTRIES; i++) begin
            snap_gh[i] = '0;
            snap_idx[i] = '0;
            snap_cnt[i] = '0;
            snap_way[i] = '0;
            snap_ok[i] = 1'b0;
        end
        // entry 0 is written while in reset
        snap_way[0] = RESET_WAY;
        snap_ok[0] = 1'b1;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        reset_values();
        index_and_history();
        calls_and_returns();
        history_restore();
        ras_restore();
        random_mix();
        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
